//--- avr_pkg.sv
package avr_pkg;

	localparam int DATA_W = 8;
	localparam int INSTR_W = 16;
	localparam int REG_IDX_W = 5;
	localparam int IO_ADDR_W = 6;

	localparam int PC_W_DEFAULT = 12;

	// Status register bit positions
	localparam logic [2:0] SREG_C = 3'd0;
	localparam logic [2:0] SREG_Z = 3'd1;
	localparam logic [2:0] SREG_N = 3'd2;
	localparam logic [2:0] SREG_V = 3'd3;
	localparam logic [2:0] SREG_S = 3'd4;
	localparam logic [2:0] SREG_H = 3'd5;
	localparam logic [2:0] SREG_T = 3'd6;
	localparam logic [2:0] SREG_I = 3'd7;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		OP_AND,
		OP_OR,
		OP_EOR,
		OP_CP,
		OP_MOV,
		OP_LDI,
		OP_SUBI,
		OP_ANDI,
		OP_ORI,
		OP_CPI,
		OP_RJMP,
		OP_BRBS,
		OP_BRBC,
		OP_OUT
	} avr_op_e;

endpackage

//--- instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
	input  logic [avr_pkg::INSTR_W-1:0]   i_instr,
	output avr_pkg::avr_op_e              o_op,
	output logic [avr_pkg::REG_IDX_W-1:0] o_rd,
	output logic [avr_pkg::REG_IDX_W-1:0] o_rr,
	output logic [avr_pkg::DATA_W-1:0]    o_imm,
	output logic [6:0]                    o_br_offset,
	output logic [2:0]                    o_br_bit,
	output logic [11:0]                   o_jmp_offset,
	output logic [avr_pkg::IO_ADDR_W-1:0] o_io_addr
);

	logic imm_form;

	always_comb
	begin
		o_op = avr_pkg::OP_NOP; // Also covers 0xFFFF and dropped opcodes
		case (i_instr[15:12])
			4'h0:
				if (i_instr[11])
					o_op = i_instr[10] ? avr_pkg::OP_ADD : avr_pkg::OP_SBC;
			4'h1:
				case (i_instr[11:10])
					2'b01: o_op = avr_pkg::OP_CP;
					2'b10: o_op = avr_pkg::OP_SUB;
					2'b11: o_op = avr_pkg::OP_ADC;
					default: o_op = avr_pkg::OP_NOP; // CPSE slot
				endcase
			4'h2:
				case (i_instr[11:10])
					2'b00: o_op = avr_pkg::OP_AND;
					2'b01: o_op = avr_pkg::OP_EOR;
					2'b10: o_op = avr_pkg::OP_OR;
					default: o_op = avr_pkg::OP_MOV;
				endcase
			4'h3: o_op = avr_pkg::OP_CPI;
			4'h5: o_op = avr_pkg::OP_SUBI;
			4'h6: o_op = avr_pkg::OP_ORI;
			4'h7: o_op = avr_pkg::OP_ANDI;
			4'hB:
				if (i_instr[11])
					o_op = avr_pkg::OP_OUT;
			4'hC: o_op = avr_pkg::OP_RJMP;
			4'hE: o_op = avr_pkg::OP_LDI;
			4'hF:
				// Bit 10 picks BRBC over BRBS
				if (!i_instr[11])
					o_op = i_instr[10] ? avr_pkg::OP_BRBC : avr_pkg::OP_BRBS;
			default: o_op = avr_pkg::OP_NOP;
		endcase
	end

	assign imm_form = o_op inside {avr_pkg::OP_LDI, avr_pkg::OP_SUBI, avr_pkg::OP_ANDI,
		avr_pkg::OP_ORI, avr_pkg::OP_CPI};

	// Immediate forms only reach r16..r31
	assign o_rd = imm_form ? {1'b1, i_instr[7:4]} : i_instr[8:4];
	assign o_rr = {i_instr[9], i_instr[3:0]};
	assign o_imm = {i_instr[11:8], i_instr[3:0]};
	assign o_br_offset = i_instr[9:3];
	assign o_br_bit = i_instr[2:0];
	assign o_jmp_offset = i_instr[11:0];
	assign o_io_addr = {i_instr[10:9], i_instr[3:0]};

endmodule

//--- register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic                          ALU_CLK,
	input  logic                          hclk,
	input  logic [avr_pkg::REG_IDX_W-1:0] i_rd_idx,
	input  logic [avr_pkg::REG_IDX_W-1:0] i_rr_idx,
	input  logic                          i_we,
	input  logic [avr_pkg::DATA_W-1:0]    i_wdata,
	output logic [avr_pkg::DATA_W-1:0]    o_rd_data,
	output logic [avr_pkg::DATA_W-1:0]    o_rr_data
);

	logic [avr_pkg::DATA_W-1:0] regs [2**avr_pkg::REG_IDX_W];

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			for (int i = 0; i < 2**avr_pkg::REG_IDX_W; i++)
				regs[i] <= '0;
		end
		else if (i_we)
			regs[i_rd_idx] <= i_wdata; // Destination is always rd
	end

	assign o_rd_data = regs[i_rd_idx];
	assign o_rr_data = regs[i_rr_idx];

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu (
	input  logic                       ALU_CLK,
	input  logic                       hclk,
	input  avr_pkg::avr_op_e           i_op,
	input  logic [avr_pkg::DATA_W-1:0] i_rd_data,
	input  logic [avr_pkg::DATA_W-1:0] i_rr_data,
	input  logic [avr_pkg::DATA_W-1:0] i_imm,
	output logic [avr_pkg::DATA_W-1:0] o_result,
	output logic                       o_we,
	output logic [7:0]                 o_sreg
);

	localparam int MSB = avr_pkg::DATA_W - 1;

	logic [7:0] sreg;
	logic [7:0] sreg_next;
	logic [avr_pkg::DATA_W-1:0] op_b;
	logic [avr_pkg::DATA_W-1:0] cin_ext;
	logic [avr_pkg::DATA_W-1:0] sum;
	logic [avr_pkg::DATA_W-1:0] diff;
	logic add_c, add_h, add_v;
	logic sub_c, sub_h, sub_v;
	logic set_nzs;

	assign op_b = (i_op inside {avr_pkg::OP_LDI, avr_pkg::OP_SUBI, avr_pkg::OP_ANDI,
		avr_pkg::OP_ORI, avr_pkg::OP_CPI}) ? i_imm : i_rr_data;

	// Carry or borrow in only for ADC and SBC
	assign cin_ext = {{MSB{1'b0}},
		(i_op inside {avr_pkg::OP_ADC, avr_pkg::OP_SBC}) & sreg[avr_pkg::SREG_C]};

	assign sum = i_rd_data + op_b + cin_ext;
	assign diff = i_rd_data - op_b - cin_ext;

	assign add_c = (i_rd_data[MSB] & op_b[MSB]) | (op_b[MSB] & ~sum[MSB]) | (i_rd_data[MSB] & ~sum[MSB]);
	assign add_h = (i_rd_data[3] & op_b[3]) | (op_b[3] & ~sum[3]) | (i_rd_data[3] & ~sum[3]);
	assign add_v = (i_rd_data[MSB] & op_b[MSB] & ~sum[MSB]) | (~i_rd_data[MSB] & ~op_b[MSB] & sum[MSB]);
	assign sub_c = (~i_rd_data[MSB] & op_b[MSB]) | (op_b[MSB] & diff[MSB]) | (~i_rd_data[MSB] & diff[MSB]);
	assign sub_h = (~i_rd_data[3] & op_b[3]) | (op_b[3] & diff[3]) | (~i_rd_data[3] & diff[3]);
	assign sub_v = (i_rd_data[MSB] & ~op_b[MSB] & ~diff[MSB]) | (~i_rd_data[MSB] & op_b[MSB] & diff[MSB]);

	always_comb
	begin
		sreg_next = sreg;
		o_result = '0;
		set_nzs = 1'b1;
		case (i_op)
			avr_pkg::OP_ADD, avr_pkg::OP_ADC:
			begin
				o_result = sum;
				sreg_next[avr_pkg::SREG_C] = add_c;
				sreg_next[avr_pkg::SREG_H] = add_h;
				sreg_next[avr_pkg::SREG_V] = add_v;
			end
			avr_pkg::OP_SUB, avr_pkg::OP_SBC, avr_pkg::OP_SUBI, avr_pkg::OP_CP, avr_pkg::OP_CPI:
			begin
				o_result = diff;
				sreg_next[avr_pkg::SREG_C] = sub_c;
				sreg_next[avr_pkg::SREG_H] = sub_h;
				sreg_next[avr_pkg::SREG_V] = sub_v;
			end
			avr_pkg::OP_AND, avr_pkg::OP_ANDI:
			begin
				o_result = i_rd_data & op_b;
				sreg_next[avr_pkg::SREG_V] = 1'b0;
			end
			avr_pkg::OP_OR, avr_pkg::OP_ORI:
			begin
				o_result = i_rd_data | op_b;
				sreg_next[avr_pkg::SREG_V] = 1'b0;
			end
			avr_pkg::OP_EOR:
			begin
				o_result = i_rd_data ^ op_b;
				sreg_next[avr_pkg::SREG_V] = 1'b0;
			end
			avr_pkg::OP_MOV, avr_pkg::OP_LDI:
			begin
				o_result = op_b; // Flags untouched
				set_nzs = 1'b0;
			end
			default: set_nzs = 1'b0;
		endcase
		if (set_nzs)
		begin
			sreg_next[avr_pkg::SREG_N] = o_result[MSB];
			// SBC keeps Z only if it was already set
			sreg_next[avr_pkg::SREG_Z] = (o_result == '0) &&
				(i_op != avr_pkg::OP_SBC || sreg[avr_pkg::SREG_Z]);
			sreg_next[avr_pkg::SREG_S] = o_result[MSB] ^ sreg_next[avr_pkg::SREG_V];
		end
	end

	assign o_we = i_op inside {avr_pkg::OP_ADD, avr_pkg::OP_ADC, avr_pkg::OP_SUB, avr_pkg::OP_SBC,
		avr_pkg::OP_AND, avr_pkg::OP_OR, avr_pkg::OP_EOR, avr_pkg::OP_MOV, avr_pkg::OP_LDI,
		avr_pkg::OP_SUBI, avr_pkg::OP_ANDI, avr_pkg::OP_ORI};

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
			sreg <= '0;
		else
			sreg <= sreg_next;
	end

	assign o_sreg = sreg;

endmodule

//--- program_counter.sv
`timescale 1ns/100ps

module program_counter #(
	parameter int PC_W = avr_pkg::PC_W_DEFAULT
) (
	input  logic             ALU_CLK,
	input  logic             hclk,
	input  avr_pkg::avr_op_e i_op,
	input  logic [7:0]       i_sreg,
	input  logic [2:0]       i_br_bit,
	input  logic [6:0]       i_br_offset,
	input  logic [11:0]      i_jmp_offset,
	output logic [PC_W-1:0]  o_pc
);

	logic [PC_W-1:0] pc_inc;
	logic [PC_W-1:0] br_ext;
	logic [PC_W-1:0] jmp_ext;
	logic [PC_W-1:0] pc_next;

	assign pc_inc = o_pc + PC_W'(1);
	assign br_ext = PC_W'(signed'(i_br_offset)); // Sign extended, wraps with the PC
	assign jmp_ext = PC_W'(signed'(i_jmp_offset));

	always_comb
	begin
		case (i_op)
			avr_pkg::OP_RJMP: pc_next = pc_inc + jmp_ext;
			avr_pkg::OP_BRBS: pc_next = i_sreg[i_br_bit] ? pc_inc + br_ext : pc_inc;
			avr_pkg::OP_BRBC: pc_next = i_sreg[i_br_bit] ? pc_inc : pc_inc + br_ext;
			default: pc_next = pc_inc;
		endcase
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
			o_pc <= '0;
		else
			o_pc <= pc_next;
	end

endmodule

//--- io_port.sv
`timescale 1ns/100ps

module io_port (
	input  logic                          ALU_CLK,
	input  logic                          hclk,
	input  avr_pkg::avr_op_e              i_op,
	input  logic [avr_pkg::IO_ADDR_W-1:0] i_addr,
	input  logic [avr_pkg::DATA_W-1:0]    i_data,
	output logic [avr_pkg::IO_ADDR_W-1:0] o_io_addr,
	output logic [avr_pkg::DATA_W-1:0]    o_io_data,
	output logic                          o_io_we
);

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			o_io_addr <= '0;
			o_io_data <= '0;
			o_io_we <= 1'b0;
		end
		else
		begin
			o_io_we <= (i_op == avr_pkg::OP_OUT); // Back to back OUTs keep it high
			if (i_op == avr_pkg::OP_OUT)
			begin
				o_io_addr <= i_addr;
				o_io_data <= i_data;
			end
		end
	end

endmodule

//--- avr_core.sv
`timescale 1ns/100ps

module avr_core #(
	parameter int PC_W = avr_pkg::PC_W_DEFAULT
) (
	input  logic                          ALU_CLK,
	input  logic                          hclk,
	input  logic [avr_pkg::INSTR_W-1:0]   i_instr,
	output logic [PC_W-1:0]               o_pc,
	output logic [7:0]                    o_sreg,
	output logic [avr_pkg::IO_ADDR_W-1:0] o_io_addr,
	output logic [avr_pkg::DATA_W-1:0]    o_io_data,
	output logic                          o_io_we
);

	avr_pkg::avr_op_e op;
	logic [avr_pkg::REG_IDX_W-1:0] rd_idx;
	logic [avr_pkg::REG_IDX_W-1:0] rr_idx;
	logic [avr_pkg::DATA_W-1:0] imm;
	logic [6:0] br_offset;
	logic [2:0] br_bit;
	logic [11:0] jmp_offset;
	logic [avr_pkg::IO_ADDR_W-1:0] io_addr;
	logic [avr_pkg::DATA_W-1:0] rd_data;
	logic [avr_pkg::DATA_W-1:0] rr_data;
	logic [avr_pkg::DATA_W-1:0] alu_result;
	logic reg_we;

	instr_decoder instr_decoder_inst (
		.i_instr(i_instr), .o_op(op), .o_rd(rd_idx), .o_rr(rr_idx), .o_imm(imm),
		.o_br_offset(br_offset), .o_br_bit(br_bit), .o_jmp_offset(jmp_offset),
		.o_io_addr(io_addr)
	);

	register_file register_file_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_rd_idx(rd_idx), .i_rr_idx(rr_idx),
		.i_we(reg_we), .i_wdata(alu_result), .o_rd_data(rd_data), .o_rr_data(rr_data)
	);

	alu alu_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_op(op), .i_rd_data(rd_data), .i_rr_data(rr_data),
		.i_imm(imm), .o_result(alu_result), .o_we(reg_we), .o_sreg(o_sreg)
	);

	// Branches test the status register as it stood before this instruction
	program_counter #(.PC_W(PC_W)) program_counter_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_op(op), .i_sreg(o_sreg), .i_br_bit(br_bit),
		.i_br_offset(br_offset), .i_jmp_offset(jmp_offset), .o_pc(o_pc)
	);

	io_port io_port_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_op(op), .i_addr(io_addr), .i_data(rd_data),
		.o_io_addr(o_io_addr), .o_io_data(o_io_data), .o_io_we(o_io_we)
	);

endmodule

//--- avr_core_properties.sv
`timescale 1ns/100ps

module avr_core_properties #(
	parameter int PC_W = avr_pkg::PC_W_DEFAULT
) (
	input logic             ALU_CLK,
	input logic             hclk,
	input avr_pkg::avr_op_e op,
	input logic [PC_W-1:0]  o_pc,
	input logic             o_io_we
);

	int assert_fails = 0;

	// No strobe during reset
	assert property (@(posedge ALU_CLK) hclk |-> !o_io_we)
	else
	begin
		$error("io write strobe high during reset");
		assert_fails++;
	end

	assert property (@(posedge ALU_CLK) $fell(hclk) |-> o_pc == '0)
	else
	begin
		$error("pc not zero in first cycle after reset");
		assert_fails++;
	end

	// Strobe follows a decoded OUT by one edge
	assert property (@(posedge ALU_CLK) disable iff (hclk)
		$rose(o_io_we) |-> $past(op) == avr_pkg::OP_OUT)
	else
	begin
		$error("io write strobe rose without an OUT");
		assert_fails++;
	end

endmodule

//--- avr_core_tb.sv
`timescale 1ns/100ps

module avr_core_tb;

	localparam int PC_W = 12;
	localparam int MEM_WORDS = 4096;
	localparam int T3_PAIRS = 60;
	localparam int T5_CYCLES = 2100;
	// Reset cycles per test plus the cycles each test runs
	localparam int TOTAL_CYCLES = 5 * 5 + 20 + (16 + 2 * T3_PAIRS + 4) + 80 + T5_CYCLES;

	logic ALU_CLK;
	logic hclk;
	logic [15:0] i_instr;
	logic [PC_W-1:0] o_pc;
	logic [7:0] o_sreg;
	logic [5:0] o_io_addr;
	logic [7:0] o_io_data;
	logic o_io_we;

	logic [15:0] mem [MEM_WORDS];
	logic [7:0] m_regs [32];
	logic [7:0] m_sreg;
	int m_pc;
	logic [5:0] m_io_addr;
	logic [7:0] m_io_data;
	logic m_io_we;
	int check_errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	avr_core #(.PC_W(PC_W)) avr_core_inst (
		.ALU_CLK(ALU_CLK), .hclk(hclk), .i_instr(i_instr), .o_pc(o_pc), .o_sreg(o_sreg),
		.o_io_addr(o_io_addr), .o_io_data(o_io_data), .o_io_we(o_io_we)
	);

	always #50 ALU_CLK = ~ALU_CLK;

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			check_errors++;
			test_errors++;
		end
	endtask

	function automatic logic [15:0] enc_rr(input logic [5:0] opc, input int d, input int r);
		logic [4:0] rr;
		logic [4:0] dd;
		rr = r[4:0];
		dd = d[4:0];
		return {opc, rr[4], dd, rr[3:0]};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [3:0] nib, input int d, input logic [7:0] k);
		logic [4:0] dd;
		dd = d[4:0];
		return {nib, k[7:4], dd[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_out(input logic [5:0] a, input int d);
		logic [4:0] dd;
		dd = d[4:0];
		return {5'b10111, a[5:4], dd, a[3:0]};
	endfunction

	// Small offsets that never jump onto themselves
	function automatic int rand_offset();
		int v;
		v = $urandom % 15;
		return (v < 7) ? v + 1 : -(v - 5);
	endfunction

	function automatic logic [15:0] rand_alu(input int d, input int r);
		logic [5:0] rr_ops [9];
		logic [3:0] imm_ops [4];
		int pick;
		rr_ops = '{6'b000011, 6'b000111, 6'b000110, 6'b000010, 6'b000101,
			6'b001000, 6'b001010, 6'b001001, 6'b001011};
		imm_ops = '{4'h3, 4'h5, 4'h7, 4'h6}; // CPI SUBI ANDI ORI
		pick = $urandom % 13;
		if (pick < 9)
			return enc_rr(rr_ops[pick], d, r);
		return enc_imm(imm_ops[pick-9], d, 8'($urandom));
	endfunction

	function automatic logic [15:0] rand_instr();
		int w;
		int off;
		w = $urandom % 100;
		off = rand_offset();
		if (w < 3)
			return {4'hC, 12'(off)};
		if (w < 8)
			return {5'b11110, 1'($urandom), 7'(off), 3'($urandom)};
		if (w < 20)
			return enc_out(6'($urandom), 16 + $urandom % 16);
		if (w < 32)
			return enc_imm(4'hE, 16 + $urandom % 16, 8'($urandom));
		return rand_alu(16 + $urandom % 16, 16 + $urandom % 16);
	endfunction

	task automatic set_flags(input logic [7:0] res, input logic v, input logic z_keep);
		m_sreg[3] = v;
		m_sreg[2] = res[7];
		m_sreg[1] = (res == 8'd0) && (!z_keep || m_sreg[1]);
		m_sreg[4] = res[7] ^ v;
	endtask

	task automatic arith(input int d, input int b, input logic sub, input int cin,
		input logic z_keep, input logic wr);
		int a;
		logic [7:0] res;
		a = m_regs[d];
		if (sub)
		begin
			res = 8'(a - b - cin);
			m_sreg[0] = a < b + cin;
			m_sreg[5] = (a % 16) < (b % 16) + cin;
			set_flags(res, (a[7] != b[7]) && (res[7] != a[7]), z_keep);
		end
		else
		begin
			res = 8'(a + b + cin);
			m_sreg[0] = (a + b + cin) > 255;
			m_sreg[5] = (a % 16) + (b % 16) + cin > 15;
			set_flags(res, (a[7] == b[7]) && (res[7] != a[7]), 1'b0);
		end
		if (wr)
			m_regs[d] = res;
	endtask

	task automatic logic_op(input int d, input logic [7:0] res);
		m_regs[d] = res;
		set_flags(res, 1'b0, 1'b0);
	endtask

	task automatic model_step(input logic [15:0] ins);
		int d;
		int r;
		int hd;
		logic [7:0] k;
		int next_pc;
		d = ins[8:4];
		r = {ins[9], ins[3:0]};
		hd = 16 + ins[7:4];
		k = {ins[11:8], ins[3:0]};
		next_pc = m_pc + 1;
		m_io_we = 1'b0;
		casez (ins)
			16'b0000_11??_????_????: arith(d, m_regs[r], 1'b0, 0, 1'b0, 1'b1);
			16'b0001_11??_????_????: arith(d, m_regs[r], 1'b0, m_sreg[0], 1'b0, 1'b1);
			16'b0001_10??_????_????: arith(d, m_regs[r], 1'b1, 0, 1'b0, 1'b1);
			16'b0000_10??_????_????: arith(d, m_regs[r], 1'b1, m_sreg[0], 1'b1, 1'b1);
			16'b0001_01??_????_????: arith(d, m_regs[r], 1'b1, 0, 1'b0, 1'b0);
			16'b0010_00??_????_????: logic_op(d, m_regs[d] & m_regs[r]);
			16'b0010_01??_????_????: logic_op(d, m_regs[d] ^ m_regs[r]);
			16'b0010_10??_????_????: logic_op(d, m_regs[d] | m_regs[r]);
			16'b0010_11??_????_????: m_regs[d] = m_regs[r];
			16'b0011_????_????_????: arith(hd, k, 1'b1, 0, 1'b0, 1'b0);
			16'b0101_????_????_????: arith(hd, k, 1'b1, 0, 1'b0, 1'b1);
			16'b0110_????_????_????: logic_op(hd, m_regs[hd] | k);
			16'b0111_????_????_????: logic_op(hd, m_regs[hd] & k);
			16'b1110_????_????_????: m_regs[hd] = k;
			16'b1011_1???_????_????:
			begin
				m_io_we = 1'b1;
				m_io_addr = {ins[10:9], ins[3:0]};
				m_io_data = m_regs[d];
			end
			16'b1100_????_????_????: next_pc = m_pc + 1 + int'(signed'(ins[11:0]));
			16'b1111_0???_????_????:
				if (m_sreg[ins[2:0]] == !ins[10]) // Taken when the bit matches S or C
					next_pc = m_pc + 1 + int'(signed'(ins[9:3]));
			default: ;
		endcase
		m_pc = next_pc & (MEM_WORDS - 1);
	endtask

	task automatic step_cycle();
		logic [15:0] ins;
		@(posedge ALU_CLK);
		ins = i_instr;
		model_step(ins);
		#1;
		check_val("pc", o_pc, m_pc);
		check_val("sreg", o_sreg, m_sreg);
		check_val("io_we", o_io_we, m_io_we);
		check_val("io_addr", o_io_addr, m_io_addr);
		check_val("io_data", o_io_data, m_io_data);
		i_instr = mem[o_pc];
	endtask

	task automatic reset_core();
		hclk = 1'b1;
		repeat (3) @(posedge ALU_CLK);
		#1;
		hclk = 1'b0;
		foreach (m_regs[i])
			m_regs[i] = 8'd0;
		m_sreg = 8'd0;
		m_pc = 0;
		m_io_we = 1'b0;
		m_io_addr = 6'd0;
		m_io_data = 8'd0;
		i_instr = mem[0];
	endtask

	task automatic fill_random();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = rand_instr();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name, (test_errors == 0) ? "PASS" : "FAIL");
		test_errors = 0;
	endtask

	initial
	begin
		#(TOTAL_CYCLES * 100 * 2);
		$display("Watchdog expired before the tests completed");
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		logic [7:0] imms [8];
		logic [5:0] addrs [8];
		int d;
		int pc;
		int assert_fails;
		ALU_CLK = 1'b0;
		hclk = 1'b1;
		i_instr = 16'h0000;
		check_errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(39));

		fill_random();
		reset_core();
		check_val("pc after reset", o_pc, 0);
		check_val("sreg after reset", o_sreg, 0);
		check_val("io_we after reset", o_io_we, 0);
		finish_test("reset state");

		for (int i = 0; i < 8; i++)
		begin
			imms[i] = 8'($urandom);
			addrs[i] = 6'($urandom);
			mem[i] = enc_imm(4'hE, 16 + i, imms[i]);
			mem[8 + i] = enc_out(addrs[i], 16 + i);
		end
		mem[16] = 16'h0000;
		reset_core();
		repeat (8) step_cycle();
		for (int i = 0; i < 8; i++)
		begin
			step_cycle();
			check_val("out data", o_io_data, imms[i]);
			check_val("out addr", o_io_addr, addrs[i]);
			check_val("out strobe", o_io_we, 1);
		end
		step_cycle();
		check_val("strobe after last out", o_io_we, 0);
		finish_test("ldi and out");

		for (int i = 0; i < 16; i++)
			mem[i] = enc_imm(4'hE, 16 + i, 8'($urandom));
		for (int i = 0; i < T3_PAIRS; i++)
		begin
			d = 16 + $urandom % 16;
			mem[16 + 2 * i] = rand_alu(d, 16 + $urandom % 16);
			mem[17 + 2 * i] = enc_out(6'($urandom), d);
		end
		reset_core();
		repeat (16 + 2 * T3_PAIRS) step_cycle();
		finish_test("alu sequences");

		fill_random();
		pc = 0;
		for (int b = 0; b < 8; b++)
		begin
			for (int s = 0; s < 2; s++)
			begin
				mem[pc] = rand_alu(16 + $urandom % 16, 16 + $urandom % 16);
				mem[pc + 1] = {5'b11110, 1'(s), 7'(1), 3'(b)}; // Taken skips the NOP
				mem[pc + 2] = 16'h0000;
				pc += 3;
			end
		end
		mem[pc] = {4'hC, 12'(5)};
		mem[pc + 6] = {4'hC, 12'(-4)};
		reset_core();
		repeat (80) step_cycle();
		finish_test("branches and jumps");

		fill_random();
		reset_core();
		repeat (T5_CYCLES) step_cycle();
		finish_test("random program");

		assert_fails = avr_core_inst.avr_core_properties_inst.assert_fails;
		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d, failed assertions: %0d",
			tests_run, tests_failed, check_errors, assert_fails);
		if (tests_failed == 0 && assert_fails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

bind avr_core avr_core_properties #(.PC_W(PC_W)) avr_core_properties_inst (
	.ALU_CLK(ALU_CLK), .hclk(hclk), .op(op), .o_pc(o_pc), .o_io_we(o_io_we)
);

//--- avr_core.f
avr_pkg.sv
instr_decoder.sv
register_file.sv
alu.sv
program_counter.sv
io_port.sv
avr_core.sv
avr_core_properties.sv
avr_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= avr_core_tb
FILELIST ?= avr_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
